/* logic/rv_params.svh */
// Core parameters
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Address of the first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential PC increment, one 32-bit instruction
`define RV_PC_STEP 32'd4

// Low address bits that must be zero for a word access
`define RV_WORD_ALIGN_BITS 2

`endif

/* logic/rv_pkg.sv */
// Core types
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_SYSTEM   = 7'b1110011,
    OPC_AUIPC    = 7'b0010111,
    OPC_LUI      = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LUI,
    CLS_AUIPC,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_LOAD,
    CLS_STORE,
    CLS_HALT,
    CLS_NOP
  } op_class_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_HALTED
  } core_state_e;

  typedef struct packed {
    op_class_e  op_class;
    logic [2:0] funct3;
    logic       alt;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
  } decoded_t;

  typedef struct packed {
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } rf_write_t;

endpackage

/* logic/rv_regfile.sv */
// Integer register file
module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_idx_t  i_rs1,
  input  rv_pkg::reg_idx_t  i_rs2,
  output rv_pkg::word_t     o_rs1_data,
  output rv_pkg::word_t     o_rs2_data,
  input  rv_pkg::rf_write_t i_exec_wr,
  input  rv_pkg::rf_write_t i_load_wr
);
  import rv_pkg::*;

  word_t regs [32];

  // x0 always reads as zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Execute and load writes never occur in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_exec_wr.we && i_exec_wr.rd != '0) begin
      regs[i_exec_wr.rd] <= i_exec_wr.data;
    end else if (i_load_wr.we && i_load_wr.rd != '0) begin
      regs[i_load_wr.rd] <= i_load_wr.data;
    end
  end

endmodule

/* logic/rv_decoder.sv */
// Instruction decoder
module rv_decoder (
  input  rv_pkg::word_t    i_insn,
  output rv_pkg::decoded_t o_dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  op_class_e  op_class;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(i_insn[6:0]);
  assign funct7 = i_insn[31:25];
  assign funct3 = i_insn[14:12];

  // Sign-extended immediates of each format
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  // Unknown and M-extension encodings fall through as NOP
  always_comb begin
    op_class = CLS_NOP;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          op_class = CLS_ALU_REG;
        end
      end
      OPC_OP_IMM: op_class = CLS_ALU_IMM;
      OPC_LUI:    op_class = CLS_LUI;
      OPC_AUIPC:  op_class = CLS_AUIPC;
      OPC_BRANCH: op_class = CLS_BRANCH;
      OPC_JAL:    op_class = CLS_JAL;
      OPC_JALR:   op_class = CLS_JALR;
      // Word accesses only
      OPC_LOAD:   op_class = (funct3 == 3'b010) ? CLS_LOAD : CLS_NOP;
      OPC_STORE:  op_class = (funct3 == 3'b010) ? CLS_STORE : CLS_NOP;
      OPC_SYSTEM: op_class = (i_insn[31:7] == '0) ? CLS_HALT : CLS_NOP;
      default:    op_class = CLS_NOP;
    endcase
  end

  always_comb begin
    o_dec.op_class = op_class;
    o_dec.funct3   = funct3;
    o_dec.alt      = i_insn[30];
    o_dec.rd       = i_insn[11:7];
    o_dec.rs1      = i_insn[19:15];
    o_dec.rs2      = i_insn[24:20];
    case (op_class)
      CLS_STORE:            o_dec.imm = imm_s;
      CLS_BRANCH:           o_dec.imm = imm_b;
      CLS_JAL:              o_dec.imm = imm_j;
      CLS_LUI, CLS_AUIPC:   o_dec.imm = imm_u;
      default:              o_dec.imm = imm_i;
    endcase
  end

endmodule

/* logic/rv_alu.sv */
// Integer ALU and branch unit
`include "rv_params.svh"

module rv_alu (
  input  rv_pkg::decoded_t i_dec,
  input  rv_pkg::word_t    i_pc,
  input  rv_pkg::word_t    i_rs1_data,
  input  rv_pkg::word_t    i_rs2_data,
  output rv_pkg::word_t    o_result,
  output rv_pkg::word_t    o_target,
  output logic             o_taken
);
  import rv_pkg::*;

  word_t      op_b;
  word_t      sum;
  word_t      sra_out;
  word_t      alu_out;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       cond;

  // Second operand is rs2 only for register-register ops
  assign op_b  = (i_dec.op_class == CLS_ALU_REG) ? i_rs2_data : i_dec.imm;
  assign sum   = i_rs1_data + op_b;
  assign shamt = op_b[4:0];

  // Arithmetic shift kept apart so the sign fills from the left
  assign sra_out = $signed(i_rs1_data) >>> shamt;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_dec.funct3)
      3'b000: begin
        // SUB only exists in the register form
        if (i_dec.op_class == CLS_ALU_REG && i_dec.alt) begin
          alu_out = i_rs1_data - i_rs2_data;
        end else begin
          alu_out = sum;
        end
      end
      3'b001: alu_out = i_rs1_data << shamt;
      3'b010: alu_out = {31'd0, $signed(i_rs1_data) < $signed(op_b)};
      3'b011: alu_out = {31'd0, i_rs1_data < op_b};
      3'b100: alu_out = i_rs1_data ^ op_b;
      3'b101: alu_out = i_dec.alt ? sra_out : i_rs1_data >> shamt;
      3'b110: alu_out = i_rs1_data | op_b;
      default: alu_out = i_rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (i_dec.op_class)
      CLS_ALU_REG, CLS_ALU_IMM: o_result = alu_out;
      CLS_LUI:                  o_result = i_dec.imm;
      CLS_AUIPC:                o_result = i_pc + i_dec.imm;
      CLS_JAL, CLS_JALR:        o_result = i_pc + `RV_PC_STEP;
      default:                  o_result = sum;
    endcase
  end

  always_comb begin
    case (i_dec.funct3)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = lt;
      3'b101:  cond = !lt;
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign o_taken  = (i_dec.op_class == CLS_BRANCH) && cond;
  // JALR target has bit 0 cleared
  assign o_target = (i_dec.op_class == CLS_JALR) ? {sum[31:1], 1'b0} : i_pc + i_dec.imm;

endmodule

/* logic/rv_fetch_unit.sv */
// Instruction fetch and sequencing
`include "rv_params.svh"

module rv_fetch_unit (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::decoded_t    i_dec,
  input  rv_pkg::word_t       i_alu_result,
  input  rv_pkg::word_t       i_alu_target,
  input  logic                i_alu_taken,
  input  logic                i_rsp_valid,
  input  rv_pkg::word_t       i_rsp_data,
  output rv_pkg::mem_req_t    o_req,
  output rv_pkg::word_t       o_pc,
  output rv_pkg::word_t       o_insn,
  output rv_pkg::rf_write_t   o_exec_wr,
  output rv_pkg::core_state_e o_state,
  output logic                o_halt
);
  import rv_pkg::*;

  core_state_e state;
  core_state_e state_next;
  word_t       pc;
  word_t       pc_next;
  word_t       insn;
  logic        writes_rd;
  logic        redirect;

  assign writes_rd = (i_dec.op_class inside {CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_AUIPC,
                                              CLS_JAL, CLS_JALR});
  assign redirect  = (i_dec.op_class == CLS_JAL) || (i_dec.op_class == CLS_JALR) || i_alu_taken;
  assign pc_next   = redirect ? i_alu_target : pc + `RV_PC_STEP;

  always_comb begin
    case (state)
      ST_FETCH:  state_next = ST_DECODE;
      ST_DECODE: state_next = ST_EXECUTE;
      ST_EXECUTE: begin
        if (i_dec.op_class == CLS_HALT) begin
          state_next = ST_HALTED;
        end else if (i_dec.op_class == CLS_LOAD || i_dec.op_class == CLS_STORE) begin
          state_next = ST_MEMORY;
        end else begin
          state_next = ST_FETCH;
        end
      end
      ST_MEMORY: state_next = ST_FETCH;
      default:   state_next = ST_HALTED;
    endcase
  end

  // Reset parks in MEMORY so the first fetch follows release by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_MEMORY;
      pc    <= `RV_RESET_PC;
      insn  <= '0;
    end else begin
      state <= state_next;
      if (state == ST_DECODE && i_rsp_valid) begin
        insn <= i_rsp_data;
      end
      if (state == ST_EXECUTE) begin
        pc <= pc_next;
      end
    end
  end

  always_comb begin
    o_req.req        = (state == ST_FETCH);
    o_req.we         = 1'b0;
    o_req.addr       = pc;
    o_req.wdata      = '0;
    o_exec_wr.we     = (state == ST_EXECUTE) && writes_rd;
    o_exec_wr.rd     = i_dec.rd;
    o_exec_wr.data   = i_alu_result;
  end

  assign o_pc    = pc;
  assign o_insn  = insn;
  assign o_state = state;
  assign o_halt  = (state == ST_HALTED);

endmodule

/* logic/rv_lsu.sv */
// Word load/store unit
`include "rv_params.svh"

module rv_lsu (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::core_state_e i_state,
  input  rv_pkg::decoded_t    i_dec,
  input  rv_pkg::word_t       i_addr,
  input  rv_pkg::word_t       i_rs2_data,
  input  logic                i_rsp_valid,
  input  rv_pkg::word_t       i_rsp_data,
  output rv_pkg::mem_req_t    o_req,
  output rv_pkg::rf_write_t   o_load_wr
);
  import rv_pkg::*;

  logic     is_mem;
  logic     aligned;
  logic     issue;
  logic     is_store;
  logic     load_pending;
  reg_idx_t load_rd;

  assign is_store = (i_dec.op_class == CLS_STORE);
  assign is_mem   = (i_state == ST_EXECUTE) && (i_dec.op_class == CLS_LOAD || is_store);
  // Misaligned words are dropped here
  assign aligned  = (i_addr[`RV_WORD_ALIGN_BITS-1:0] == '0);
  assign issue    = is_mem && aligned;

  always_ff @(posedge clk) begin
    if (rst) begin
      load_pending <= 1'b0;
    end else begin
      load_pending <= issue && !is_store;
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !is_store) begin
      load_rd <= i_dec.rd;
    end
  end

  always_comb begin
    o_req.req      = issue;
    o_req.we       = issue && is_store;
    o_req.addr     = i_addr;
    o_req.wdata    = i_rs2_data;
    o_load_wr.we   = i_rsp_valid && load_pending;
    o_load_wr.rd   = load_rd;
    o_load_wr.data = i_rsp_data;
  end

endmodule

/* logic/rv_mem_arbiter.sv */
// Memory port arbiter
module rv_mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::mem_req_t i_fetch_req,
  input  rv_pkg::mem_req_t i_lsu_req,
  output logic             o_fetch_rsp_valid,
  output logic             o_lsu_rsp_valid,
  output logic             o_mem_req,
  output logic             o_mem_we,
  output rv_pkg::word_t    o_mem_addr,
  output rv_pkg::word_t    o_mem_wdata
);
  import rv_pkg::*;

  mem_req_t sel;
  logic     grant_lsu;
  logic     read_pending;

  // LSU wins when both ask
  assign sel = i_lsu_req.req ? i_lsu_req : i_fetch_req;

  assign o_mem_req   = sel.req;
  assign o_mem_we    = sel.we;
  assign o_mem_addr  = sel.addr;
  assign o_mem_wdata = sel.wdata;

  // Grant record for the read data returning next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_lsu    <= 1'b0;
      read_pending <= 1'b0;
    end else begin
      grant_lsu    <= i_lsu_req.req;
      read_pending <= sel.req && !sel.we;
    end
  end

  assign o_fetch_rsp_valid = read_pending && !grant_lsu;
  assign o_lsu_rsp_valid   = read_pending && grant_lsu;

endmodule

/* logic/rv_core.sv */
// RV32I multi-cycle core
module rv_core (
  input  logic          clk,
  input  logic          rst,
  output logic          o_mem_req,
  output logic          o_mem_we,
  output rv_pkg::word_t o_mem_addr,
  output rv_pkg::word_t o_mem_wdata,
  input  rv_pkg::word_t i_mem_rdata,
  output logic          o_halt
);
  import rv_pkg::*;

  decoded_t    dec;
  core_state_e state;
  word_t       pc;
  word_t       insn;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       alu_result;
  word_t       alu_target;
  logic        alu_taken;
  mem_req_t    fetch_req;
  mem_req_t    lsu_req;
  logic        fetch_rsp_valid;
  logic        lsu_rsp_valid;
  rf_write_t   exec_wr;
  rf_write_t   load_wr;

  rv_fetch_unit i_fetch (
    .clk(clk), .rst(rst), .i_dec(dec),
    .i_alu_result(alu_result), .i_alu_target(alu_target), .i_alu_taken(alu_taken),
    .i_rsp_valid(fetch_rsp_valid), .i_rsp_data(i_mem_rdata),
    .o_req(fetch_req), .o_pc(pc), .o_insn(insn), .o_exec_wr(exec_wr),
    .o_state(state), .o_halt(o_halt)
  );

  rv_decoder i_decoder (.i_insn(insn), .o_dec(dec));

  rv_regfile i_regfile (
    .clk(clk), .rst(rst), .i_rs1(dec.rs1), .i_rs2(dec.rs2),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_exec_wr(exec_wr), .i_load_wr(load_wr)
  );

  rv_alu i_alu (
    .i_dec(dec), .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_result(alu_result), .o_target(alu_target), .o_taken(alu_taken)
  );

  rv_lsu i_lsu (
    .clk(clk), .rst(rst), .i_state(state), .i_dec(dec),
    .i_addr(alu_result), .i_rs2_data(rs2_data),
    .i_rsp_valid(lsu_rsp_valid), .i_rsp_data(i_mem_rdata),
    .o_req(lsu_req), .o_load_wr(load_wr)
  );

  rv_mem_arbiter i_arbiter (
    .clk(clk), .rst(rst), .i_fetch_req(fetch_req), .i_lsu_req(lsu_req),
    .o_fetch_rsp_valid(fetch_rsp_valid), .o_lsu_rsp_valid(lsu_rsp_valid),
    .o_mem_req(o_mem_req), .o_mem_we(o_mem_we),
    .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
  );

endmodule

/* testbench/rv_core_properties.sv */
// Core port checks
module rv_core_properties (
  input logic        clk,
  input logic        rst,
  input logic        i_mem_req,
  input logic        i_mem_we,
  input logic [31:0] i_mem_addr,
  input logic        i_halt
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int fail_count = 0;

  a_write_has_req: assert property (@(posedge clk) disable iff (rst) i_mem_we |-> i_mem_req)
    else begin
      $error("Memory write strobe raised without a request");
      fail_count++;
    end

  // Every request on the word port is aligned
  a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    i_mem_req |-> (i_mem_addr[1:0] == 2'b00))
    else begin
      $error("Memory request address is not word aligned");
      fail_count++;
    end

  // Only a reset may clear the halt
  a_halt_sticky: assert property (@(posedge clk) i_halt && !rst |=> i_halt)
    else begin
      $error("Halt output dropped without a reset");
      fail_count++;
    end

  a_quiet_when_halted: assert property (@(posedge clk) disable iff (rst) i_halt |-> !i_mem_req)
    else begin
      $error("Memory request issued while halted");
      fail_count++;
    end

endmodule

/* testbench/tb_rv_core.sv */
// RV32I core testbench
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [31:0] ECALL     = 32'h0000_0073;
  localparam logic [31:0] FENCE     = 32'h0ff0_000f;
  localparam int DATA_BASE    = 1024;
  localparam int HALT_TIMEOUT = 2000;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] i_mem_rdata = '0;
  logic        o_mem_req;
  logic        o_mem_we;
  logic [31:0] o_mem_addr;
  logic [31:0] o_mem_wdata;
  logic        o_halt;

  logic [31:0] mem [1024];
  logic [9:0]  rd_idx = '0;
  logic [31:0] wr_addr_q[$];
  logic [31:0] wr_data_q[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_data_q[$];
  logic [31:0] prog_pc;
  logic [15:0] lfsr_state;

  rv_core i_rv_core (
    .clk(clk), .rst(rst), .o_mem_req(o_mem_req), .o_mem_we(o_mem_we),
    .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
    .o_halt(o_halt)
  );

  bind rv_core rv_core_properties i_properties (
    .clk(clk), .rst(rst), .i_mem_req(o_mem_req), .i_mem_we(o_mem_we),
    .i_mem_addr(o_mem_addr), .i_halt(o_halt)
  );

  always #50 clk = ~clk;

  // Writes land at the request edge and reads return a cycle later
  always @(posedge clk) begin
    if (o_mem_req === 1'b1) begin
      if (o_mem_we) begin
        mem[o_mem_addr[11:2]] = o_mem_wdata;
        wr_addr_q.push_back(o_mem_addr);
        wr_data_q.push_back(o_mem_wdata);
      end else begin
        rd_idx <= o_mem_addr[11:2];
      end
    end
  end

  always @(negedge clk) begin
    i_mem_rdata <= mem[rd_idx];
  end

  always @(negedge clk) begin
    assert (i_rv_core.i_properties.fail_count == 0) else begin
      $display("A bound property assertion failed at %0t", $time);
      report_failure();
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    logic [9:0] a;
    a = idx[9:0];
    return {~a, 6'h15, a, 6'h2a};
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Reference results from the ISA definitions
  function automatic logic [31:0] expect_alu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic expect_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic report_failure();
    $display("test failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic emit(input logic [31:0] insn);
    mem[prog_pc[11:2]] = insn;
    prog_pc = prog_pc + 32'd4;
  endtask

  // Emit a SW off the x31 base and queue it when on the correct path
  task automatic store_word(input logic [4:0] rs2, input int off, input logic expected,
                            input logic [31:0] value);
    emit(enc_s(12'(off), rs2, 5'd31));
    if (expected) begin
      exp_addr_q.push_back(32'(DATA_BASE + off));
      exp_data_q.push_back(value);
    end
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, OPC_LUI));
    emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic begin_program();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(i);
    end
    prog_pc = '0;
    exp_addr_q.delete();
    exp_data_q.delete();
    emit(enc_i(12'(DATA_BASE), 5'd0, 3'b000, 5'd31, OPC_OP_IMM));
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (2) @(negedge clk);
    assert (!o_halt && !o_mem_req && !o_mem_we) else begin
      $display("ERR %0t: halt, request or write strobe high during reset", $time);
      report_failure();
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    rst = 1'b0;
  endtask

  task automatic wait_halt(input string what);
    int cycles;
    cycles = 0;
    while (!o_halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (o_halt) else begin
      $display("%s: the core did not halt within %0d cycles", what, HALT_TIMEOUT);
      report_failure();
    end
  endtask

  task automatic check_stores(input string what);
    check_word({what, " store count"}, 32'(wr_addr_q.size()), 32'(exp_addr_q.size()));
    for (int i = 0; i < exp_addr_q.size(); i++) begin
      check_word({what, " store address"}, wr_addr_q[i], exp_addr_q[i]);
      check_word({what, " store data"}, wr_data_q[i], exp_data_q[i]);
    end
  endtask

  task automatic run_program(input string what);
    apply_reset();
    wait_halt(what);
    check_stores(what);
  endtask

  task automatic reset_and_first_fetch();
    int cycles;
    begin_program();
    emit(enc_i(12'h001, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    store_word(5'd1, 0, 1'b1, 32'd1);
    emit(ECALL);
    apply_reset();
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!o_mem_req && cycles < 8);
    assert (o_mem_req) else begin
      $display("No memory request appeared after reset was released");
      report_failure();
    end
    check_word("first request cycle", 32'(cycles), 32'd1);
    check_word("first request write", {31'd0, o_mem_we}, 32'd0);
    check_word("first request address", o_mem_addr, 32'd0);
    wait_halt("reset");
    check_stores("reset");
  endtask

  task automatic alu_operations();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm12;
    int          off;
    begin_program();
    off = 0;
    for (int round = 0; round < 2; round++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
        store_word(5'd3, off, 1'b1, expect_alu(3'(f3), 1'b0, a, b));
        off += 4;
      end
      // SUB and SRA
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
      store_word(5'd3, off, 1'b1, expect_alu(3'b000, 1'b1, a, b));
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
      store_word(5'd3, off + 4, 1'b1, expect_alu(3'b101, 1'b1, a, b));
      off += 8;
      for (int f3 = 0; f3 < 8; f3++) begin
        imm12 = 12'(rand_bits(12));
        if (f3 == 1 || f3 == 5) begin
          imm12[11:5] = 7'h00;
        end
        emit(enc_i(imm12, 5'd1, 3'(f3), 5'd4, OPC_OP_IMM));
        store_word(5'd4, off, 1'b1, expect_alu(3'(f3), 1'b0, a, {{20{imm12[11]}}, imm12}));
        off += 4;
      end
      imm12 = {7'h20, 5'(rand_bits(5))};
      emit(enc_i(imm12, 5'd1, 3'b101, 5'd4, OPC_OP_IMM));
      store_word(5'd4, off, 1'b1, expect_alu(3'b101, 1'b1, a, {20'd0, imm12}));
      off += 4;
    end
    // Writes to x0 are discarded
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    emit(enc_i(12'h5a5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
    store_word(5'd0, off, 1'b1, 32'd0);
    emit(ECALL);
    run_program("alu");
  endtask

  task automatic upper_immediates();
    logic [19:0] u;
    logic [31:0] pc;
    int          off;
    begin_program();
    off = 0;
    for (int k = 0; k < 3; k++) begin
      u = 20'(rand_bits(20));
      emit(enc_u(u, 5'd5, OPC_LUI));
      store_word(5'd5, off, 1'b1, {u, 12'h000});
      u = 20'(rand_bits(20));
      pc = prog_pc;
      emit(enc_u(u, 5'd6, OPC_AUIPC));
      store_word(5'd6, off + 4, 1'b1, pc + {u, 12'h000});
      off += 8;
    end
    emit(ECALL);
    run_program("upper");
  endtask

  task automatic branches_and_jumps();
    logic [31:0] a_vals [4];
    logic [31:0] b_vals [4];
    logic [2:0]  kinds [6];
    logic        taken;
    logic [31:0] pc0;
    int          k;
    int          off;
    begin_program();
    a_vals = '{32'd5, 32'hffff_fffd, 32'd2, rand_bits(32)};
    b_vals = '{32'd5, 32'd2, 32'hffff_fffd, rand_bits(32)};
    kinds  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    k = 0;
    off = 0;
    for (int p = 0; p < 4; p++) begin
      load_const(5'd1, a_vals[p]);
      load_const(5'd2, b_vals[p]);
      for (int j = 0; j < 6; j++) begin
        taken = expect_taken(kinds[j], a_vals[p], b_vals[p]);
        // Taken skips the fall-through marker pair
        emit(enc_b(13'd12, 5'd2, 5'd1, kinds[j]));
        emit(enc_i(12'h100 + 12'(k), 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        store_word(5'd7, off, !taken, 32'h100 + 32'(k));
        emit(enc_i(12'h200 + 12'(k), 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        store_word(5'd7, off + 4, 1'b1, 32'h200 + 32'(k));
        off += 8;
        k++;
      end
    end
    pc0 = prog_pc;
    emit(enc_j(21'd12, 5'd8));
    emit(enc_i(12'h3aa, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    store_word(5'd7, off, 1'b0, 32'd0);
    store_word(5'd8, off + 4, 1'b1, pc0 + 32'd4);
    // JALR aims one past the target and the low bit must be cleared
    pc0 = prog_pc;
    emit(enc_i(12'(pc0 + 32'd16), 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
    emit(enc_i(12'd1, 5'd9, 3'b000, 5'd10, OPC_JALR));
    emit(enc_i(12'h3bb, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    store_word(5'd7, off + 8, 1'b0, 32'd0);
    store_word(5'd10, off + 12, 1'b1, pc0 + 32'd8);
    emit(ECALL);
    run_program("branch");
  endtask

  task automatic load_store_words();
    logic [31:0] v;
    begin_program();
    v = rand_bits(32);
    load_const(5'd1, v);
    store_word(5'd1, 0, 1'b1, v);
    emit(enc_i(12'd0, 5'd31, 3'b010, 5'd11, OPC_LOAD));
    store_word(5'd11, 4, 1'b1, v);
    // Misaligned SW and LW are dropped
    store_word(5'd1, 9, 1'b0, 32'd0);
    emit(enc_i(12'h155, 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
    emit(enc_i(12'd2, 5'd31, 3'b010, 5'd12, OPC_LOAD));
    store_word(5'd12, 8, 1'b1, 32'h155);
    emit(enc_i(12'd64, 5'd31, 3'b010, 5'd13, OPC_LOAD));
    store_word(5'd13, 12, 1'b1, fill_word((DATA_BASE + 64) / 4));
    emit(ECALL);
    run_program("load store");
  endtask

  task automatic halt_behavior();
    begin_program();
    emit(enc_i(12'h077, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
    load_const(5'd1, rand_bits(32));
    load_const(5'd2, rand_bits(32));
    // MUL and FENCE leave x3 alone
    emit(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(FENCE);
    store_word(5'd3, 0, 1'b1, 32'h77);
    emit(ECALL);
    store_word(5'd3, 4, 1'b0, 32'd0);
    run_program("halt");
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_word("halt held", {31'd0, o_halt}, 32'd1);
      check_word("request while halted", {31'd0, o_mem_req}, 32'd0);
    end
    check_stores("halt");
  endtask

  initial begin
    lfsr_state = 16'd3633;
    prog_pc = '0;
    reset_and_first_fetch();
    alu_operations();
    upper_immediates();
    branches_and_jumps();
    load_store_words();
    halt_behavior();
    if (i_rv_core.i_properties.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "Bound property assertions failed");
    end
  end

endmodule

/* files.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_fetch_unit.sv
logic/rv_lsu.sv
logic/rv_mem_arbiter.sv
logic/rv_core.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv
